// ==== upd78.f ====
upd78_pkg.sv
upd78_clkgen.sv
upd78_ucode_rom.sv
upd78_dispatch.sv
upd78_core.sv
upd78_top.sv
tb_upd78.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the upd78 testbench with Verilator
# exit status is nonzero when the build or the simulation fails

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_upd78

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_upd78 \
  -f upd78.f \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit 1
fi

echo "simulation ended normally"
exit 0

// ==== tb_upd78.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 testbench
// runs a short program from a memory model and compares every
// opcode fetch and every write with a table of expected events
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_upd78
  import upd78_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int MAX_EV     = 32;

  // dut ports
  logic        CLK = 1'b0;
  logic        reset;
  logic        INT;
  logic [7:0]  DB_I;
  logic [15:0] A;
  logic [7:0]  DB_O;
  logic        DB_OE;
  logic        WR;
  logic        M1;

  // 256 byte memory decoded on the low address byte
  logic [7:0]  mem [0:255];

  // expected events in bus order
  logic        ev_wr   [MAX_EV];
  logic [15:0] ev_addr [MAX_EV];
  logic [7:0]  ev_data [MAX_EV];
  logic        ev_int  [MAX_EV];
  int          n_ev;
  int          ev_idx;

  // monitor state
  logic        m1_q;
  logic        wr_q;
  int          wr_left;
  int          int_delay;
  int          int_cnt;
  int          clk_cnt;
  longint      timeout_ns;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  upd78_top u_dut (
    .CLK   (CLK),
    .reset (reset),
    .INT   (INT),
    .DB_I  (DB_I),
    .A     (A),
    .DB_O  (DB_O),
    .DB_OE (DB_OE),
    .WR    (WR),
    .M1    (M1)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic put_byte(input logic [15:0] addr, input logic [7:0] val);
    mem[addr[7:0]] = val;
  endtask

  task automatic add_event(input logic is_wr, input logic [15:0] addr,
                           input logic [7:0] data, input logic raise_int);
    ev_wr[n_ev]   = is_wr;
    ev_addr[n_ev] = addr;
    ev_data[n_ev] = data;
    ev_int[n_ev]  = raise_int;
    n_ev          = n_ev + 1;
  endtask

  // compare one fetch or write seen on the bus with the next row
  task automatic take_event(input logic is_wr, input logic [15:0] addr,
                            input logic [7:0] data);
    check_eq(32'(ev_idx < n_ev), 32'd1, "bus event past the end of the table");
    check_eq(32'(is_wr), 32'(ev_wr[ev_idx]), $sformatf("event %0d kind (1 = write)", ev_idx));
    check_eq(32'(addr), 32'(ev_addr[ev_idx]), $sformatf("event %0d address", ev_idx));
    if (is_wr) begin
      check_eq(32'(data), 32'(ev_data[ev_idx]), $sformatf("event %0d write data", ev_idx));
      // write state lasts one machine state of 4 CLK
      wr_left = 4;
    end
    if (ev_int[ev_idx]) begin
      int_cnt = int_delay + 1;
    end
    ev_idx = ev_idx + 1;
  endtask

  task automatic load_program();
    // address dependent fill under the program bytes
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'hA5;
    end
    put_byte(16'h0000, OP_NOP);
    put_byte(16'h0001, OP_NOP);
    put_byte(16'h0002, OP_MVI_A);
    put_byte(16'h0003, 8'h5A);
    put_byte(16'h0004, OP_STAX);
    put_byte(16'h0005, 8'hF0);
    put_byte(16'h0006, 8'h00);
    put_byte(16'h0007, OP_MVI_A);
    put_byte(16'h0008, 8'hC3);
    put_byte(16'h0009, OP_STAX);
    put_byte(16'h000A, 8'hF1);
    put_byte(16'h000B, 8'h12);
    // undefined opcode
    put_byte(16'h000C, 8'hFF);
    put_byte(16'h000D, OP_JMP);
    put_byte(16'h000E, 8'h40);
    put_byte(16'h000F, 8'h01);
    // jump target 0140 aliases to byte 40
    put_byte(16'h0140, OP_NOP);
    put_byte(16'h0141, OP_DI);
    put_byte(16'h0142, OP_NOP);
    put_byte(16'h0143, OP_EI);
    // interrupt entry
    put_byte(INT_VECTOR,         OP_NOP);
    put_byte(INT_VECTOR + 16'd1, OP_NOP);
    put_byte(INT_VECTOR + 16'd2, OP_NOP);
  endtask

  task automatic load_events();
    // write flag, address, write data, raise INT after this event
    add_event(1'b0, 16'h0000, 8'h00, 1'b0);
    add_event(1'b0, 16'h0001, 8'h00, 1'b0);
    add_event(1'b0, 16'h0002, 8'h00, 1'b0);
    add_event(1'b0, 16'h0004, 8'h00, 1'b0);
    add_event(1'b1, 16'h00F0, 8'h5A, 1'b0);
    add_event(1'b0, 16'h0007, 8'h00, 1'b0);
    add_event(1'b0, 16'h0009, 8'h00, 1'b0);
    add_event(1'b1, 16'h12F1, 8'hC3, 1'b0);
    add_event(1'b0, 16'h000C, 8'h00, 1'b0);
    add_event(1'b0, 16'h000D, 8'h00, 1'b0);
    // ie still clear from reset when INT rises
    add_event(1'b0, 16'h0140, 8'h00, 1'b1);
    add_event(1'b0, 16'h0141, 8'h00, 1'b0);
    add_event(1'b0, 16'h0142, 8'h00, 1'b0);
    add_event(1'b0, 16'h0143, 8'h00, 1'b0);
    // EI lets the held INT in and the entry clears ie again
    add_event(1'b0, INT_VECTOR,         8'h00, 1'b0);
    add_event(1'b0, INT_VECTOR + 16'd1, 8'h00, 1'b0);
    add_event(1'b0, INT_VECTOR + 16'd2, 8'h00, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model and bus monitor

  always @(posedge CLK) begin
    DB_I <= mem[A[7:0]];
    if (WR) begin
      mem[A[7:0]] = DB_O;
    end
  end

  always @(posedge CLK) begin
    if (!reset) begin
      if (int_cnt > 0) begin
        int_cnt = int_cnt - 1;
        if (int_cnt == 0) begin
          INT <= 1'b1;
        end
      end
      if (M1 && !m1_q) begin
        take_event(1'b0, A, 8'h00);
      end
      if (WR && !wr_q) begin
        take_event(1'b1, A, DB_O);
      end
      // bus rules on every clock
      check_eq(32'(M1 & WR), 32'd0, "M1 and WR high together");
      check_eq(32'(WR), 32'(wr_left > 0), "WR level against the write state");
      check_eq(32'(DB_OE), 32'(wr_left > 0), "DB_OE level against the write state");
      if (wr_left > 0) begin
        wr_left = wr_left - 1;
      end
    end
    m1_q = M1;
    wr_q = WR;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    reset   <= 1'b1;
    INT     <= 1'b0;
    DB_I    <= 8'h00;
    m1_q    = 1'b0;
    wr_q    = 1'b0;
    wr_left = 0;
    int_cnt = 0;
    n_ev    = 0;
    ev_idx  = 0;
    void'($urandom(32'h0eb9781c));
    // INT rises within the NOP at 0140
    int_delay = int'($urandom % 8);
    load_program();
    load_events();
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
    check_eq(32'(M1), 32'd0, "M1 after reset");
    check_eq(32'(WR), 32'd0, "WR after reset");
    check_eq(32'(DB_OE), 32'd0, "DB_OE after reset");
    clk_cnt = 1;
    while (!M1) begin
      @(posedge CLK);
      clk_cnt = clk_cnt + 1;
    end
    check_eq(32'(clk_cnt <= 8), 32'd1, "first M1 later than two machine states");
    wait (ev_idx == n_ev);
    $display("Result: PASSED");
    $finish;
  end

  // 16 machine states per event plus reset and slack
  initial begin
    #1;
    timeout_ns = longint'(n_ev * 16 + 20) * 4 * CLK_PERIOD;
    #(timeout_ns);
    $display("watchdog expired, program hung after %0d of %0d events", ev_idx, n_ev);
    $display("Result: FAILED");
    $fatal(1, "simulation timeout");
  end

endmodule

// ==== upd78_top.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 top level
// phase generator and core on the external memory bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module upd78_top (
  input  logic        CLK,
  input  logic        reset,
  input  logic        INT,
  input  logic [7:0]  DB_I,
  output logic [15:0] A,
  output logic [7:0]  DB_O,
  output logic        DB_OE,
  output logic        WR,
  output logic        M1
);

  // phase strobes, cp1n has no user in the core
  logic cp1p;
  logic cp2p;
  logic cp2n;

  upd78_clkgen u_clkgen (
    .CLK   (CLK),
    .reset (reset),
    .cp1p  (cp1p),
    .cp1n  (),
    .cp2p  (cp2p),
    .cp2n  (cp2n)
  );

  upd78_core u_core (
    .CLK   (CLK),
    .reset (reset),
    .cp1p  (cp1p),
    .cp2p  (cp2p),
    .cp2n  (cp2n),
    .INT   (INT),
    .DB_I  (DB_I),
    .A     (A),
    .DB_O  (DB_O),
    .DB_OE (DB_OE),
    .WR    (WR),
    .M1    (M1)
  );

endmodule

// ==== upd78_core.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 core
// microsequencer and datapath: pc, ir, a, address latch w, ie,
// address and data output registers and the bus control outputs,
// all stepped by the phase strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module upd78_core
  import upd78_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        cp1p,
  input  logic        cp2p,
  input  logic        cp2n,
  input  logic        INT,
  input  logic [7:0]  DB_I,
  output logic [15:0] A,
  output logic [7:0]  DB_O,
  output logic        DB_OE,
  output logic        WR,
  output logic        M1
);

  // microsequencer
  s_uc        uc;
  s_uc        rom_uc;
  e_uaddr     uptr;
  e_uaddr     uptr_next;
  e_uaddr     at;

  // datapath
  logic [15:0] pc;
  logic [15:0] pc_plus1;
  logic [7:0]  upc;
  logic [7:0]  ir;
  logic [7:0]  a;
  logic [15:0] w;
  logic        ie;
  logic        ie_eff;
  logic        int_take;
  logic [15:0] aor;
  logic [7:0]  dor;
  logic [7:0]  idb;

  //////////////////////////////////////////////////////////////////////
  // microcode

  upd78_ucode_rom u_rom (
    .uaddr (uptr),
    .uc    (rom_uc)
  );

  upd78_dispatch u_dispatch (
    .ir (ir),
    .at (at)
  );

  // ie as seen by the fetch check, EI/DI take effect at once
  assign ie_eff   = (uc.drs == URS_IE) ? uc.idx : ie;
  assign int_take = INT & ie_eff;

  always_comb begin
    uptr_next = uptr;
    case (uc.bm)
      UBM_ADV:   uptr_next = e_uaddr'(uptr + 6'd1);
      UBM_DA:    uptr_next = uc.nua;
      UBM_AT:    uptr_next = at;
      UBM_FETCH: uptr_next = int_take ? UA_INT_T1 : uc.nua;
      default:   ;
    endcase
  end

  // uaddr moves at cp2p
  always_ff @(posedge CLK) begin
    if (reset) begin
      uptr <= UA_FETCH_T1;
    end else if (cp2p) begin
      uptr <= uptr_next;
    end
  end

  // next microword at cp2n, first state out of reset is idle
  always_ff @(posedge CLK) begin
    if (reset) begin
      uc <= UC_IDLE;
    end else if (cp2n) begin
      uc <= rom_uc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // internal data bus

  // bus data on reads, otherwise vector bytes for interrupt entry
  always_comb begin
    if (uc.rd) begin
      idb = DB_I;
    end else if (uc.drs == URS_PCH) begin
      idb = INT_VECTOR[15:8];
    end else begin
      idb = INT_VECTOR[7:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers, loaded at cp2n

  assign pc_plus1 = pc + 16'd1;

  // pch write completes a jump using the held low byte
  always_ff @(posedge CLK) begin
    if (reset) begin
      pc <= 16'h0000;
    end else if (cp2n) begin
      if (uc.drs == URS_PCH) begin
        pc <= {idb, upc};
      end else if (uc.pc_inc) begin
        pc <= pc_plus1;
      end
    end
  end

  // new pc low byte, held until the high byte arrives
  always_ff @(posedge CLK) begin
    if (cp2n && uc.drs == URS_PCL) begin
      upc <= idb;
    end
  end

  always_ff @(posedge CLK) begin
    if (cp2n && uc.irl) begin
      ir <= idb;
    end
  end

  always_ff @(posedge CLK) begin
    if (cp2n && uc.drs == URS_A) begin
      a <= idb;
    end
  end

  // direct address for stax
  always_ff @(posedge CLK) begin
    if (cp2n) begin
      if (uc.drs == URS_WL) begin
        w[7:0] <= idb;
      end
      if (uc.drs == URS_WH) begin
        w[15:8] <= idb;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ie <= 1'b0;
    end else if (cp2n && uc.drs == URS_IE) begin
      ie <= uc.idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // external bus, registered at cp1p

  // address holds when neither source is selected
  always_ff @(posedge CLK) begin
    if (cp1p) begin
      if (uc.pc_ab) begin
        aor <= pc;
      end else if (uc.w_ab) begin
        aor <= w;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cp1p && uc.wr) begin
      dor <= a;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      M1    <= 1'b0;
      WR    <= 1'b0;
      DB_OE <= 1'b0;
    end else if (cp1p) begin
      M1    <= uc.m1;
      WR    <= uc.wr;
      DB_OE <= uc.wr;
    end
  end

  assign A    = aor;
  assign DB_O = dor;

  // bus driven only while writing
  a_oe_needs_wr : assert property (
    @(posedge CLK) disable iff (reset) DB_OE |-> WR
  );

  // microcode never fetches and writes in one state
  a_m1_wr_excl : assert property (
    @(posedge CLK) disable iff (reset) !(M1 && WR)
  );

endmodule

// ==== upd78_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 opcode dispatch
// maps the instruction register to the entry address of its
// microcode routine; unknown opcodes restart the fetch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module upd78_dispatch
  import upd78_pkg::*;
(
  input  logic [7:0] ir,
  output e_uaddr     at
);

  always_comb begin
    case (ir)
      OP_NOP:   at = UA_NOP;
      OP_EI:    at = UA_EI;
      OP_DI:    at = UA_DI;
      OP_MVI_A: at = UA_MVI_T1;
      OP_JMP:   at = UA_JMP_T1;
      OP_STAX:  at = UA_STAX_T1;
      // undefined: behaves as a bare fetch
      default:  at = UA_FETCH_T1;
    endcase
  end

endmodule

// ==== upd78_ucode_rom.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 microcode store
// constant table of microwords, one routine per instruction plus
// the opcode fetch and the interrupt entry sequence
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module upd78_ucode_rom
  import upd78_pkg::*;
(
  input  e_uaddr uaddr,
  output s_uc    uc
);

  always_comb begin
    // unlisted entries fall back to fetch
    uc = UC_IDLE;
    case (uaddr)
      //////////////////////////////////////////////////////////////////////
      // opcode fetch
      UA_FETCH_T1: begin
        // pc out with M1
        uc.bm    = UBM_ADV;
        uc.pc_ab = 1'b1;
        uc.m1    = 1'b1;
        uc.rd    = 1'b1;
      end
      UA_FETCH_T2: begin
        // address held, opcode into ir
        uc.bm     = UBM_ADV;
        uc.m1     = 1'b1;
        uc.rd     = 1'b1;
        uc.irl    = 1'b1;
        uc.pc_inc = 1'b1;
      end
      UA_DISPATCH: begin
        uc.bm = UBM_AT;
      end

      //////////////////////////////////////////////////////////////////////
      // interrupt entry
      UA_INT_T1: begin
        // mask further interrupts
        uc.bm  = UBM_ADV;
        uc.drs = URS_IE;
        uc.idx = 1'b0;
      end
      UA_INT_T2: begin
        // vector low byte
        uc.bm  = UBM_ADV;
        uc.drs = URS_PCL;
      end
      UA_INT_T3: begin
        // vector high byte, pc loads here
        uc.bm  = UBM_DA;
        uc.nua = UA_FETCH_T1;
        uc.drs = URS_PCH;
      end

      //////////////////////////////////////////////////////////////////////
      // one state instructions
      UA_NOP: begin
        uc = UC_IDLE;
      end
      UA_EI: begin
        uc.drs = URS_IE;
        uc.idx = 1'b1;
      end
      UA_DI: begin
        uc.drs = URS_IE;
        uc.idx = 1'b0;
      end

      // mvi a,byte
      UA_MVI_T1: begin
        uc.pc_ab  = 1'b1;
        uc.rd     = 1'b1;
        uc.pc_inc = 1'b1;
        uc.drs    = URS_A;
      end

      // jmp word, low byte first
      UA_JMP_T1: begin
        uc.bm     = UBM_ADV;
        uc.pc_ab  = 1'b1;
        uc.rd     = 1'b1;
        uc.pc_inc = 1'b1;
        uc.drs    = URS_PCL;
      end
      UA_JMP_T2: begin
        uc.pc_ab = 1'b1;
        uc.rd    = 1'b1;
        uc.drs   = URS_PCH;
      end

      // stax word: address into w, then write a
      UA_STAX_T1: begin
        uc.bm     = UBM_ADV;
        uc.pc_ab  = 1'b1;
        uc.rd     = 1'b1;
        uc.pc_inc = 1'b1;
        uc.drs    = URS_WL;
      end
      UA_STAX_T2: begin
        uc.bm     = UBM_ADV;
        uc.pc_ab  = 1'b1;
        uc.rd     = 1'b1;
        uc.pc_inc = 1'b1;
        uc.drs    = URS_WH;
      end
      UA_STAX_T3: begin
        uc.w_ab = 1'b1;
        uc.wr   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== upd78_clkgen.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 phase generator
// splits CLK into the four two-phase strobes, one per CLK,
// rotating cp1p, cp1n, cp2p, cp2n; a machine state is 4 CLK
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module upd78_clkgen (
  input  logic CLK,
  input  logic reset,
  output logic cp1p,
  output logic cp1n,
  output logic cp2p,
  output logic cp2n
);

  // position within the machine state
  logic [1:0] phase;

  // strobes are registered, so cp1p shows in the first CLK out of reset
  always_ff @(posedge CLK) begin
    if (reset) begin
      phase <= 2'd0;
      cp1p  <= 1'b0;
      cp1n  <= 1'b0;
      cp2p  <= 1'b0;
      cp2n  <= 1'b0;
    end else begin
      phase <= phase + 2'd1;
      cp1p  <= (phase == 2'd0);
      cp1n  <= (phase == 2'd1);
      cp2p  <= (phase == 2'd2);
      cp2n  <= (phase == 2'd3);
    end
  end

  // one strobe per CLK once running
  a_strobe_onehot : assert property (
    @(posedge CLK) disable iff (reset)
    !$past(reset) |-> $onehot({cp1p, cp1n, cp2p, cp2n})
  );

endmodule

// ==== upd78_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// upd78 shared definitions
// microcode address map, microword layout, bus opcodes and the
// interrupt entry vector for the small uPD7800 family core
//////////////////////////////////////////////////////////////////////

package upd78_pkg;

  // microcode entry points
  typedef enum logic [5:0] {
    UA_FETCH_T1 = 6'd0,
    UA_FETCH_T2,
    UA_DISPATCH,
    UA_INT_T1,
    UA_INT_T2,
    UA_INT_T3,
    UA_NOP,
    UA_EI,
    UA_DI,
    UA_MVI_T1,
    UA_JMP_T1,
    UA_JMP_T2,
    UA_STAX_T1,
    UA_STAX_T2,
    UA_STAX_T3
  } e_uaddr;

  // next microaddress selection
  typedef enum logic [1:0] {
    UBM_ADV   = 2'd0,  // uaddr + 1
    UBM_DA    = 2'd1,  // nua field
    UBM_AT    = 2'd2,  // opcode dispatch
    UBM_FETCH = 2'd3   // nua, or interrupt entry
  } e_ubm;

  // internal data bus destination
  typedef enum logic [2:0] {
    URS_NONE = 3'd0,
    URS_A    = 3'd1,
    URS_IE   = 3'd2,
    URS_PCL  = 3'd3,
    URS_PCH  = 3'd4,
    URS_WL   = 3'd5,
    URS_WH   = 3'd6
  } e_urs;

  // 7801 single byte opcodes, prefixed forms folded in
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_EI    = 8'h20,
    OP_DI    = 8'h24,
    OP_JMP   = 8'h54,
    OP_MVI_A = 8'h69,
    OP_STAX  = 8'h79
  } e_opcode;

  // one microword, 19 bits
  typedef struct packed {
    e_ubm   bm;
    e_uaddr nua;
    e_urs   drs;
    logic   idx;     // value for ie
    logic   irl;     // ir <- bus
    logic   pc_ab;   // pc onto address bus
    logic   w_ab;    // address latch onto address bus
    logic   pc_inc;
    logic   m1;      // opcode fetch
    logic   rd;
    logic   wr;
  } s_uc;

  // interrupt entry address
  localparam logic [15:0] INT_VECTOR = 16'h0060;

  // no bus activity, back to an interrupt checked fetch
  localparam s_uc UC_IDLE = '{bm: UBM_FETCH, nua: UA_FETCH_T1, drs: URS_NONE,
                              default: 1'b0};

endpackage
